// ==== compile.f ====
+incdir+test
design/soc_pkg.sv
design/bus_decoder.sv
design/ram_wb8.sv
design/rom_wb8.sv
design/gpio_wb8.sv
design/timer_wb8.sv
design/soc_top.sv
test/tb_soc.sv

// ==== design/bus_decoder.sv ====
module bus_decoder import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  bus_addr_u         adr_i,
    input  logic [DATA_W-1:0] ram_dat_i,
    input  logic              ram_ack_i,
    input  logic [DATA_W-1:0] rom_dat_i,
    input  logic              rom_ack_i,
    input  logic [DATA_W-1:0] gpio_dat_i,
    input  logic              gpio_ack_i,
    input  logic [DATA_W-1:0] tmr_dat_i,
    input  logic              tmr_ack_i,
    output logic              ram_stb_o,
    output logic              rom_stb_o,
    output logic              gpio_stb_o,
    output logic              tmr_stb_o,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);

    // one decode drives both the strobes and the response mux
    always_comb begin
        ram_stb_o  = 1'b0;
        rom_stb_o  = 1'b0;
        gpio_stb_o = 1'b0;
        tmr_stb_o  = 1'b0;
        dat_o      = ram_dat_i;
        ack_o      = ram_ack_i;

        if (adr_i.mem.page == ROM_PAGE) begin
            rom_stb_o = stb_i;
            dat_o     = rom_dat_i;
            ack_o     = rom_ack_i;
        end else if (adr_i.io.page == IO_PAGE) begin
            if (adr_i.io.dev == TIMER_DEV) begin
                tmr_stb_o = stb_i;
                dat_o     = tmr_dat_i;
                ack_o     = tmr_ack_i;
            end else begin
                // unused device slots land on the gpio block
                gpio_stb_o = stb_i;
                dat_o      = gpio_dat_i;
                ack_o      = gpio_ack_i;
            end
        end else begin
            // everything else is ram, upper offset bits alias
            ram_stb_o = stb_i;
        end
    end

    // a slave answers only to an access still held by the master
    a_ack_needs_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        $rose(ack_o) |-> stb_i
    );

endmodule

// ==== design/gpio_wb8.sv ====
module gpio_wb8 import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [1:0]        adr_i,
    input  logic [DATA_W-1:0] dat_i,
    input  logic [3:0]        buttons_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic [7:0]        leds_o,
    output logic              irq_o
);

    logic [3:0] btn_meta;
    logic [3:0] btn_sync;
    logic       btn0_prev;
    logic       irq_flag;
    logic       access;
    logic       btn0_rise;

    assign access    = stb_i && !ack_o;
    assign btn0_rise = btn_sync[0] && !btn0_prev;
    assign irq_o     = irq_flag;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o     <= 1'b0;
            leds_o    <= '0;
            btn_meta  <= '0;
            btn_sync  <= '0;
            btn0_prev <= 1'b0;
            irq_flag  <= 1'b0;
        end else begin
            ack_o     <= access;
            // two flop synchronizer, then edge detect on button 0
            btn_meta  <= buttons_i;
            btn_sync  <= btn_meta;
            btn0_prev <= btn_sync[0];
            if (btn0_rise) begin
                irq_flag <= 1'b1;
            end
            if (access && we_i) begin
                case (adr_i)
                    GPIO_LEDS: leds_o <= dat_i;
                    // any write value clears the flag
                    GPIO_IRQ:  irq_flag <= 1'b0;
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                GPIO_LEDS:    dat_o <= leds_o;
                GPIO_BUTTONS: dat_o <= {{(DATA_W-4){1'b0}}, btn_sync};
                GPIO_IRQ:     dat_o <= {{(DATA_W-1){1'b0}}, irq_flag};
                default:      dat_o <= '0;
            endcase
        end
    end

endmodule

// ==== design/ram_wb8.sv ====
module ram_wb8 import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [RAM_AW-1:0] adr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);

    logic [DATA_W-1:0] mem [2**RAM_AW];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    // access happens once, on the edge that raises ack
    always_ff @(posedge clk) begin
        if (stb_i && !ack_o) begin
            if (we_i) begin
                mem[adr_i] <= dat_i;
            end
            dat_o <= mem[adr_i];
        end
    end

    a_ack_in_stb: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        ack_o |-> stb_i
    );

endmodule

// ==== design/rom_init.hex ====
// one byte per line, boot rom offsets 0 to 15, each byte is offset ^ a5
A5
A4
A7
A6
A1
A0
A3
A2
AD
AC
AF
AE
A9
A8
AB
AA

// ==== design/rom_wb8.sv ====
module rom_wb8 import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  logic [ROM_AW-1:0] adr_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o
);

    logic [DATA_W-1:0] mem [2**ROM_AW];

    // bytes past the end of the image stay zero
    initial begin
        for (int i = 0; i < 2**ROM_AW; i++) begin
            mem[i] = '0;
        end
        $readmemh(ROM_INIT_FILE, mem);
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= stb_i && !ack_o;
        end
    end

    // writes get the same ack, data is dropped
    always_ff @(posedge clk) begin
        if (stb_i && !ack_o) begin
            dat_o <= mem[adr_i];
        end
    end

endmodule

// ==== design/soc_pkg.sv ====
package soc_pkg;

    // bus data width
    localparam int DATA_W = 8;

    // memory address widths in bytes
    localparam int RAM_AW = 10;
    localparam int ROM_AW = 9;

    // 0xFFFFF000 - 0xFFFFF7FF boot rom
    localparam logic [20:0] ROM_PAGE = {20'hFFFFF, 1'b0};
    // 0xFFFFF800 - 0xFFFFFFFF i/o devices
    localparam logic [20:0] IO_PAGE = {20'hFFFFF, 1'b1};

    // i/o device slot of the timer, 0xFFFFFDxx
    localparam logic [2:0] TIMER_DEV = 3'd5;

    localparam string ROM_INIT_FILE = "design/rom_init.hex";

    // timer register selects
    localparam logic [1:0] TMR_CTRL = 2'd0;
    localparam logic [1:0] TMR_RELOAD = 2'd1;
    localparam logic [1:0] TMR_COUNT = 2'd2;
    localparam logic [1:0] TMR_STATUS = 2'd3;

    // gpio register selects
    localparam logic [1:0] GPIO_LEDS = 2'd0;
    localparam logic [1:0] GPIO_BUTTONS = 2'd1;
    localparam logic [1:0] GPIO_IRQ = 2'd2;

    // one bus address, seen as memory or as i/o space
    typedef union packed {
        struct packed {
            logic [20:0] page;
            logic [10:0] offset;
        } mem;
        struct packed {
            logic [20:0] page;
            logic [2:0]  dev;
            logic [7:0]  reg_sel;
        } io;
    } bus_addr_u;

endpackage

// ==== design/soc_top.sv ====
module soc_top import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [31:0]       adr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic              irq_o,
    input  logic [3:0]        buttons_i,
    output logic [7:0]        leds_o
);

    bus_addr_u         adr;
    logic              ram_stb, rom_stb, gpio_stb, tmr_stb;
    logic              ram_ack, rom_ack, gpio_ack, tmr_ack;
    logic [DATA_W-1:0] ram_dat, rom_dat, gpio_dat, tmr_dat;
    logic              gpio_irq, tmr_irq;

    assign adr = adr_i;

    bus_decoder u_decoder (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .stb_i      (stb_i),
        .adr_i      (adr),
        .ram_dat_i  (ram_dat),
        .ram_ack_i  (ram_ack),
        .rom_dat_i  (rom_dat),
        .rom_ack_i  (rom_ack),
        .gpio_dat_i (gpio_dat),
        .gpio_ack_i (gpio_ack),
        .tmr_dat_i  (tmr_dat),
        .tmr_ack_i  (tmr_ack),
        .ram_stb_o  (ram_stb),
        .rom_stb_o  (rom_stb),
        .gpio_stb_o (gpio_stb),
        .tmr_stb_o  (tmr_stb),
        .dat_o      (dat_o),
        .ack_o      (ack_o)
    );

    ram_wb8 u_ram (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (ram_stb),
        .we_i     (we_i),
        .adr_i    (adr.mem.offset[RAM_AW-1:0]),
        .dat_i    (dat_i),
        .dat_o    (ram_dat),
        .ack_o    (ram_ack)
    );

    rom_wb8 u_rom (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (rom_stb),
        .adr_i    (adr.mem.offset[ROM_AW-1:0]),
        .dat_o    (rom_dat),
        .ack_o    (rom_ack)
    );

    gpio_wb8 u_gpio (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .stb_i     (gpio_stb),
        .we_i      (we_i),
        .adr_i     (adr.io.reg_sel[1:0]),
        .dat_i     (dat_i),
        .buttons_i (buttons_i),
        .dat_o     (gpio_dat),
        .ack_o     (gpio_ack),
        .leds_o    (leds_o),
        .irq_o     (gpio_irq)
    );

    timer_wb8 u_timer (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .stb_i    (tmr_stb),
        .we_i     (we_i),
        .adr_i    (adr.io.reg_sel[1:0]),
        .dat_i    (dat_i),
        .dat_o    (tmr_dat),
        .ack_o    (tmr_ack),
        .irq_o    (tmr_irq)
    );

    // one cycle behind the slave interrupts
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            irq_o <= 1'b0;
        end else begin
            irq_o <= gpio_irq || tmr_irq;
        end
    end

endmodule

// ==== design/timer_wb8.sv ====
module timer_wb8 import soc_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  logic              stb_i,
    input  logic              we_i,
    input  logic [1:0]        adr_i,
    input  logic [DATA_W-1:0] dat_i,
    output logic [DATA_W-1:0] dat_o,
    output logic              ack_o,
    output logic              irq_o
);

    // ctrl bit 0 run, bit 1 interrupt enable
    logic [1:0]        ctrl;
    logic [DATA_W-1:0] reload;
    logic [DATA_W-1:0] count;
    logic              expired;
    logic              access;

    assign access = stb_i && !ack_o;
    assign irq_o  = expired && ctrl[1];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o   <= 1'b0;
            ctrl    <= '0;
            reload  <= '0;
            count   <= '0;
            expired <= 1'b0;
        end else begin
            ack_o <= access;
            if (access && we_i) begin
                case (adr_i)
                    TMR_CTRL:   ctrl <= dat_i[1:0];
                    TMR_RELOAD: begin
                        reload <= dat_i;
                        count  <= dat_i;
                    end
                    TMR_STATUS: if (dat_i[0]) expired <= 1'b0;
                    default:    ;
                endcase
            end
            // expiry is kept even when it meets a status clear
            if (ctrl[0] && !(access && we_i && adr_i == TMR_RELOAD)) begin
                if (count == '0) begin
                    count   <= reload;
                    expired <= 1'b1;
                end else begin
                    count <= count - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            case (adr_i)
                TMR_CTRL:   dat_o <= {{(DATA_W-2){1'b0}}, ctrl};
                TMR_RELOAD: dat_o <= reload;
                TMR_COUNT:  dat_o <= count;
                TMR_STATUS: dat_o <= {{(DATA_W-1){1'b0}}, expired};
                default:    dat_o <= '0;
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build with verilator and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_soc -f compile.f -o sim_soc \
    && ./obj_dir/sim_soc > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1 || exit 0

// ==== test/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

function automatic logic [31:0] io_addr(input logic [2:0] dev, input logic [1:0] sel);
    bus_addr_u a;
    a.io.page    = IO_PAGE;
    a.io.dev     = dev;
    a.io.reg_sel = {6'd0, sel};
    return a;
endfunction

function automatic logic [31:0] rom_addr(input logic [10:0] offset);
    bus_addr_u a;
    a.mem.page   = ROM_PAGE;
    a.mem.offset = offset;
    return a;
endfunction

task automatic check_byte(input string what, input logic [7:0] expected,
                          input logic [7:0] actual);
    checks++;
    assert (actual === expected) else begin
        errors++;
        $display("[ERROR] %s %s: expected %02h, actual %02h", cur_test, what, expected, actual);
    end
endtask

// one master cycle, stb held through the edge that samples ack
task automatic bus_access(input logic write, input logic [31:0] addr,
                          input logic [7:0] wdata, output logic [7:0] rdata);
    int cycles;
    @(negedge clk);
    stb    = 1'b1;
    we     = write;
    adr    = addr;
    dat_wr = wdata;
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
    end while (!ack && cycles < 20);
    rdata = dat_rd;
    if (!ack) begin
        timeouts++;
        $display("%s: no acknowledge from address %08h within 20 cycles", cur_test, addr);
    end else begin
        check_byte("ack latency", 8'd1, 8'(cycles));
        @(negedge clk);
        check_byte("ack width", 8'd0, 8'(ack));
    end
    stb = 1'b0;
    we  = 1'b0;
endtask

task automatic bus_write(input logic [31:0] addr, input logic [7:0] data);
    logic [7:0] unused;
    bus_access(1'b1, addr, data, unused);
endtask

task automatic bus_read(input logic [31:0] addr, output logic [7:0] data);
    bus_access(1'b0, addr, 8'h00, data);
endtask

task automatic wait_irq(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (irq !== level && cycles < limit) begin
        @(negedge clk);
        cycles++;
    end
    if (irq !== level) begin
        timeouts++;
        $display("%s: irq_o did not go to %0d within %0d cycles", cur_test, level, limit);
    end
endtask

task automatic test_ram();
    logic [7:0]  model [1024];
    logic [31:0] addrs [$];
    logic [31:0] a;
    logic [7:0]  d;
    cur_test = "test_ram";
    for (int i = 0; i < 32; i++) begin
        a     = $random(seed);
        // stay below the rom page
        a[31] = 1'b0;
        d     = 8'($random(seed));
        bus_write(a, d);
        model[a[9:0]] = d;
        addrs.push_back(a);
    end
    foreach (addrs[i]) begin
        bus_read(addrs[i], d);
        check_byte("readback", model[addrs[i][9:0]], d);
        bus_read(addrs[i] + 32'd1024, d);
        check_byte("alias", model[addrs[i][9:0]], d);
    end
endtask

task automatic test_rom();
    logic [7:0] d;
    cur_test = "test_rom";
    // image in ROM_INIT_FILE holds offset ^ a5 for the first 16 bytes
    for (int i = 0; i < 21; i++) begin
        bus_read(rom_addr(11'(i)), d);
        check_byte("read", (i < 16) ? (8'(i) ^ 8'hA5) : 8'h00, d);
    end
    bus_write(rom_addr(11'd3), 8'h3C);
    bus_read(rom_addr(11'd3), d);
    check_byte("after write", 8'h03 ^ 8'hA5, d);
endtask

task automatic test_gpio();
    logic [7:0] d;
    logic [7:0] r;
    cur_test = "test_gpio";
    // device slot 4 is one of the gpio slots
    repeat (4) begin
        d = 8'($random(seed));
        bus_write(io_addr(3'd4, GPIO_LEDS), d);
        check_byte("leds_o", d, leds);
        bus_read(io_addr(3'd4, GPIO_LEDS), r);
        check_byte("led readback", d, r);
    end
    buttons = 4'b1010;
    repeat (4) @(negedge clk);
    bus_read(io_addr(3'd4, GPIO_BUTTONS), r);
    check_byte("buttons", 8'h0A, r);
    check_byte("irq before press", 8'h00, 8'(irq));
    buttons = 4'b0001;
    repeat (3) @(negedge clk);
    buttons = 4'b0000;
    wait_irq(1'b1, 20);
    bus_write(io_addr(3'd4, GPIO_IRQ), 8'h5A);
    wait_irq(1'b0, 4);
    bus_read(io_addr(3'd4, GPIO_IRQ), r);
    check_byte("flag after clear", 8'h00, r);
endtask

task automatic test_timer();
    logic [7:0] r;
    int         polls;
    cur_test = "test_timer";
    bus_write(io_addr(TIMER_DEV, TMR_RELOAD), 8'd10);
    bus_write(io_addr(TIMER_DEV, TMR_CTRL), 8'h01);
    polls = 0;
    r     = 8'h00;
    while (!r[0] && polls < 20) begin
        bus_read(io_addr(TIMER_DEV, TMR_STATUS), r);
        check_byte("irq while masked", 8'h00, 8'(irq));
        polls++;
    end
    if (!r[0]) begin
        timeouts++;
        $display("%s: timer status never showed expiry", cur_test);
    end
    bus_write(io_addr(TIMER_DEV, TMR_CTRL), 8'h03);
    wait_irq(1'b1, 20);
    // stop counting so the flag cannot set again
    bus_write(io_addr(TIMER_DEV, TMR_CTRL), 8'h02);
    bus_write(io_addr(TIMER_DEV, TMR_STATUS), 8'h01);
    bus_read(io_addr(TIMER_DEV, TMR_STATUS), r);
    check_byte("status after clear", 8'h00, r);
    wait_irq(1'b0, 4);
endtask

task automatic test_io_default();
    logic [2:0] devs [4] = '{3'd0, 3'd1, 3'd2, 3'd6};
    logic [7:0] d;
    logic [7:0] r;
    cur_test = "test_io_default";
    for (int i = 0; i < 4; i++) begin
        d = 8'($random(seed));
        bus_write(io_addr(devs[i], GPIO_LEDS), d);
        check_byte("leds_o", d, leds);
        // read back through a different slot
        bus_read(io_addr(devs[(i + 1) % 4], GPIO_LEDS), r);
        check_byte("led readback", d, r);
    end
endtask

`endif

// ==== test/tb_soc.sv ====
module tb_soc import soc_pkg::*; ();

    logic        clk;
    logic        arst_n;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [7:0]  dat_wr;
    logic [3:0]  buttons;
    logic [7:0]  dat_rd;
    logic        ack;
    logic        irq;
    logic [7:0]  leds;

    integer      seed;
    int          errors;
    int          timeouts;
    int          checks;
    string       cur_test;

    soc_top dut0 (
        .clk       (clk),
        .arst_n_i  (arst_n),
        .stb_i     (stb),
        .we_i      (we),
        .adr_i     (adr),
        .dat_i     (dat_wr),
        .dat_o     (dat_rd),
        .ack_o     (ack),
        .irq_o     (irq),
        .buttons_i (buttons),
        .leds_o    (leds)
    );

    always #50 clk = ~clk;

    `include "tb_tasks.svh"

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        dat_wr   = '0;
        buttons  = '0;
        seed     = 32'h5ae1;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        cur_test = "reset";

        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // outputs cleared by reset
        check_byte("ack_o", 8'h00, 8'(ack));
        check_byte("irq_o", 8'h00, 8'(irq));
        check_byte("leds_o", 8'h00, leds);

        test_ram();
        test_rom();
        test_gpio();
        test_timer();
        test_io_default();

        $display("checks %0d  errors %0d  timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
